// ==== hw/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 1024;
    localparam int DMEM_WORDS = 1024;
    localparam int IMEM_AW    = $clog2(IMEM_WORDS);
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [7:0]      byte_t;
    typedef logic [6:0]      opcode_t;

    localparam word_t RESET_PC     = 32'h0;
    localparam word_t UART_TX_ADDR = 32'h20020;   // byte address of the tx port

    // major opcodes of the supported subset
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_AUIPC  = 7'b0010111;
    localparam opcode_t OP_JAL    = 7'b1101111;
    localparam opcode_t OP_JALR   = 7'b1100111;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_REG    = 7'b0110011;

    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;   // sub, sra

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE, EQ, NE, LT, GE, LTU, GEU
    } br_op_e;

    // encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        BYTE, HALF, WORD
    } mem_size_e;

endpackage

// ==== hw/rv_fetch.sv ====
`timescale 1ns/10ps

module rv_fetch (
    input  logic          clk,
    input  logic          reset,
    input  logic          i_stall,
    input  rv_pkg::word_t i_next_pc,
    output rv_pkg::word_t o_pc,
    output rv_pkg::word_t o_inst
);
    import rv_pkg::*;

    word_t rom [IMEM_WORDS];
    word_t pc;

    initial begin
        $readmemh("program.hex", rom);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (!i_stall) begin
            pc <= i_next_pc;   // held while tx waits
        end
    end

    assign o_pc   = pc;
    assign o_inst = rom[pc[IMEM_AW+1:2]];   // word index into rom

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::word_t     i_inst,
    output rv_pkg::reg_idx_t  o_rs1,
    output rv_pkg::reg_idx_t  o_rs2,
    output rv_pkg::reg_idx_t  o_rd,
    output rv_pkg::word_t     o_imm,
    output rv_pkg::alu_op_e   o_alu_op,
    output rv_pkg::br_op_e    o_br_op,
    output logic              o_use_imm,
    output logic              o_use_pc,
    output logic              o_jal,
    output logic              o_jalr,
    output logic              o_wb_en,
    output logic              o_load,
    output logic              o_store,
    output logic              o_load_signed,
    output rv_pkg::mem_size_e o_size
);
    import rv_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;
    logic       f7_ok;
    logic       imm_ok;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  alu_sel = sub_sra ? SUB : ADD;
            3'b001:  alu_sel = SLL;
            3'b010:  alu_sel = SLT;
            3'b011:  alu_sel = SLTU;
            3'b100:  alu_sel = XOR;
            3'b101:  alu_sel = sub_sra ? SRA : SRL;
            3'b110:  alu_sel = OR;
            default: alu_sel = AND;
        endcase
    endfunction

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign o_rd   = i_inst[11:7];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

    assign alt    = (funct7 == FUNCT7_ALT);
    assign f7_ok  = (funct7 == 7'b0) || (alt && (funct3 == 3'b000 || funct3 == 3'b101));
    assign imm_ok = (funct3[1:0] != 2'b01) || f7_ok;   // only shifts check funct7

    always_comb begin
        o_imm         = imm_i;
        o_alu_op      = ADD;
        o_br_op       = NONE;
        o_use_imm     = 1'b0;
        o_use_pc      = 1'b0;
        o_jal         = 1'b0;
        o_jalr        = 1'b0;
        o_wb_en       = 1'b0;
        o_load        = 1'b0;
        o_store       = 1'b0;
        o_load_signed = 1'b0;
        o_size        = WORD;
        case (opcode)
            OP_LUI: begin
                o_imm     = imm_u;
                o_alu_op  = PASS_B;
                o_use_imm = 1'b1;
                o_wb_en   = 1'b1;
            end
            OP_AUIPC: begin
                o_imm     = imm_u;
                o_use_pc  = 1'b1;
                o_use_imm = 1'b1;
                o_wb_en   = 1'b1;
            end
            OP_JAL: begin
                o_imm   = imm_j;
                o_jal   = 1'b1;
                o_wb_en = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == 3'b000) begin
                    o_jalr    = 1'b1;
                    o_use_imm = 1'b1;
                    o_wb_en   = 1'b1;
                end
            end
            OP_BRANCH: begin
                o_imm = imm_b;
                case (funct3)
                    3'b000:  o_br_op = EQ;
                    3'b001:  o_br_op = NE;
                    3'b100:  o_br_op = LT;
                    3'b101:  o_br_op = GE;
                    3'b110:  o_br_op = LTU;
                    3'b111:  o_br_op = GEU;
                    default: o_br_op = NONE;
                endcase
            end
            OP_LOAD: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    o_load        = 1'b1;
                    o_wb_en       = 1'b1;
                    o_use_imm     = 1'b1;
                    o_size        = mem_size_e'(funct3[1:0]);
                    o_load_signed = !funct3[2];   // lbu, lhu have bit 2 set
                end
            end
            OP_STORE: begin
                o_imm = imm_s;
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    o_store   = 1'b1;
                    o_use_imm = 1'b1;
                    o_size    = mem_size_e'(funct3[1:0]);
                end
            end
            OP_IMM: begin
                if (imm_ok) begin
                    o_alu_op  = alu_sel(funct3, (funct3 == 3'b101) && alt);
                    o_use_imm = 1'b1;
                    o_wb_en   = 1'b1;
                end
            end
            OP_REG: begin
                if (f7_ok) begin
                    o_alu_op = alu_sel(funct3, alt);
                    o_wb_en  = 1'b1;
                end
            end
            default: ;   // anything else is a no-op
        endcase
    end

endmodule

// ==== hw/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile (
    input  logic             clk,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_we,
    input  logic             i_stall,
    input  rv_pkg::word_t    i_wdata,
    output rv_pkg::word_t    o_a,
    output rv_pkg::word_t    o_b
);
    import rv_pkg::*;

    word_t regs [1:31];   // x0 has no storage

    always_ff @(posedge clk) begin
        if (i_we && !i_stall && (i_rd != 5'd0)) begin
            regs[i_rd] <= i_wdata;
        end
    end

    assign o_a = (i_rs1 == 5'd0) ? '0 : regs[i_rs1];
    assign o_b = (i_rs2 == 5'd0) ? '0 : regs[i_rs2];

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute (
    input  rv_pkg::word_t   i_pc,
    input  rv_pkg::word_t   i_a,
    input  rv_pkg::word_t   i_b,
    input  rv_pkg::word_t   i_imm,
    input  rv_pkg::alu_op_e i_alu_op,
    input  rv_pkg::br_op_e  i_br_op,
    input  logic            i_use_imm,
    input  logic            i_use_pc,
    input  logic            i_jal,
    input  logic            i_jalr,
    output rv_pkg::word_t   o_result,
    output rv_pkg::word_t   o_link,
    output rv_pkg::word_t   o_next_pc
);
    import rv_pkg::*;

    word_t      op_a;
    word_t      op_b;
    word_t      pc_plus4;
    word_t      target;
    logic [4:0] shamt;
    logic       taken;

    assign op_a  = i_use_pc ? i_pc : i_a;    // auipc adds to pc
    assign op_b  = i_use_imm ? i_imm : i_b;
    assign shamt = op_b[4:0];

    always_comb begin
        case (i_alu_op)
            ADD:     o_result = op_a + op_b;
            SUB:     o_result = op_a - op_b;
            AND:     o_result = op_a & op_b;
            OR:      o_result = op_a | op_b;
            XOR:     o_result = op_a ^ op_b;
            SLL:     o_result = op_a << shamt;
            SRL:     o_result = op_a >> shamt;
            SRA:     o_result = $signed(op_a) >>> shamt;
            SLT:     o_result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            SLTU:    o_result = {{(XLEN-1){1'b0}}, op_a < op_b};
            PASS_B:  o_result = op_b;   // lui
            default: o_result = op_a + op_b;
        endcase
    end

    // branches always compare rs1 against rs2
    always_comb begin
        case (i_br_op)
            EQ:      taken = (i_a == i_b);
            NE:      taken = (i_a != i_b);
            LT:      taken = ($signed(i_a) < $signed(i_b));
            GE:      taken = ($signed(i_a) >= $signed(i_b));
            LTU:     taken = (i_a < i_b);
            GEU:     taken = (i_a >= i_b);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = i_pc + word_t'(4);
    assign target   = i_pc + i_imm;
    assign o_link   = pc_plus4;

    always_comb begin
        if (i_jalr) begin
            o_next_pc = {o_result[XLEN-1:1], 1'b0};   // rs1 + imm, bit 0 cleared
        end else if (i_jal || taken) begin
            o_next_pc = target;
        end else begin
            o_next_pc = pc_plus4;
        end
    end

endmodule

// ==== hw/rv_lsu.sv ====
`timescale 1ns/10ps

module rv_lsu (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::word_t     i_addr,
    input  rv_pkg::word_t     i_store_data,
    input  logic              i_load,
    input  logic              i_store,
    input  logic              i_load_signed,
    input  rv_pkg::mem_size_e i_size,
    input  rv_pkg::word_t     i_result,
    input  rv_pkg::word_t     i_link,
    input  logic              i_jump_link,
    input  logic              i_uart_ready,
    output logic              o_uart_valid,
    output rv_pkg::byte_t     o_uart_data,
    output rv_pkg::word_t     o_wb_data,
    output logic              o_stall
);
    import rv_pkg::*;

    word_t              ram [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [1:0]         offset;
    logic [3:0]         lane_mask;
    logic               uart_hit;
    logic               tx_req;
    logic               tx_armed;
    word_t              wdata;
    word_t              rdata;
    word_t              shifted;
    word_t              load_data;

    assign word_idx = i_addr[DMEM_AW+1:2];
    assign offset   = i_addr[1:0];
    assign uart_hit = (i_addr == UART_TX_ADDR);
    assign tx_req   = i_store && uart_hit && (i_size == BYTE);

    always_comb begin
        case (i_size)
            BYTE: begin
                lane_mask = 4'b0001 << offset;
                wdata     = {4{i_store_data[7:0]}};   // replicated, mask picks lane
            end
            HALF: begin
                lane_mask = offset[1] ? 4'b1100 : 4'b0011;
                wdata     = {2{i_store_data[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;
                wdata     = i_store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_store && !uart_hit) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (lane_mask[lane]) begin
                    ram[word_idx][lane*8 +: 8] <= wdata[lane*8 +: 8];
                end
            end
        end
    end

    assign rdata   = ram[word_idx];
    assign shifted = rdata >> {offset, 3'b000};   // addressed lane down to bit 0

    always_comb begin
        case (i_size)
            BYTE:    load_data = {{24{i_load_signed & shifted[7]}}, shifted[7:0]};
            HALF:    load_data = {{16{i_load_signed & shifted[15]}}, shifted[15:0]};
            default: load_data = rdata;
        endcase
    end

    // tx port comes up one cycle after reset
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_armed <= 1'b0;
        end else begin
            tx_armed <= 1'b1;
        end
    end

    assign o_uart_valid = tx_req && tx_armed;
    assign o_uart_data  = i_store_data[7:0];
    assign o_stall      = tx_req && !(tx_armed && i_uart_ready);   // hold until accepted

    assign o_wb_data = i_load ? load_data : (i_jump_link ? i_link : i_result);

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
    input  logic          clk,
    input  logic          reset,
    input  logic          i_uart_ready,
    output logic          o_uart_valid,
    output rv_pkg::byte_t o_uart_data
);
    import rv_pkg::*;

    word_t     pc;
    word_t     inst;
    word_t     next_pc;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     result;
    word_t     link;
    word_t     wb_data;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    alu_op_e   alu_op;
    br_op_e    br_op;
    mem_size_e size;
    logic      use_imm;
    logic      use_pc;
    logic      jal;
    logic      jalr;
    logic      wb_en;
    logic      load;
    logic      store;
    logic      load_signed;
    logic      stall;

    rv_fetch u_fetch (
        .clk       (clk),
        .reset     (reset),
        .i_stall   (stall),
        .i_next_pc (next_pc),
        .o_pc      (pc),
        .o_inst    (inst)
    );

    rv_decode u_decode (
        .i_inst        (inst),
        .o_rs1         (rs1),
        .o_rs2         (rs2),
        .o_rd          (rd),
        .o_imm         (imm),
        .o_alu_op      (alu_op),
        .o_br_op       (br_op),
        .o_use_imm     (use_imm),
        .o_use_pc      (use_pc),
        .o_jal         (jal),
        .o_jalr        (jalr),
        .o_wb_en       (wb_en),
        .o_load        (load),
        .o_store       (store),
        .o_load_signed (load_signed),
        .o_size        (size)
    );

    rv_regfile u_regfile (
        .clk     (clk),
        .i_rs1   (rs1),
        .i_rs2   (rs2),
        .i_rd    (rd),
        .i_we    (wb_en),
        .i_stall (stall),
        .i_wdata (wb_data),
        .o_a     (rs1_data),
        .o_b     (rs2_data)
    );

    rv_execute u_execute (
        .i_pc      (pc),
        .i_a       (rs1_data),
        .i_b       (rs2_data),
        .i_imm     (imm),
        .i_alu_op  (alu_op),
        .i_br_op   (br_op),
        .i_use_imm (use_imm),
        .i_use_pc  (use_pc),
        .i_jal     (jal),
        .i_jalr    (jalr),
        .o_result  (result),
        .o_link    (link),
        .o_next_pc (next_pc)
    );

    rv_lsu u_lsu (
        .clk           (clk),
        .reset         (reset),
        .i_addr        (result),   // alu result is the effective address
        .i_store_data  (rs2_data),
        .i_load        (load),
        .i_store       (store),
        .i_load_signed (load_signed),
        .i_size        (size),
        .i_result      (result),
        .i_link        (link),
        .i_jump_link   (jal || jalr),
        .i_uart_ready  (i_uart_ready),
        .o_uart_valid  (o_uart_valid),
        .o_uart_data   (o_uart_data),
        .o_wb_data     (wb_data),
        .o_stall       (stall)
    );

endmodule

// ==== bench/rv_core_assert.sv ====
`timescale 1ns/10ps

module rv_core_assert (
    input logic          clk,
    input logic          reset,
    input logic          i_uart_ready,
    input logic          o_uart_valid,
    input rv_pkg::byte_t o_uart_data,
    input rv_pkg::word_t pc,
    input logic          stall
);

    int fail_count = 0;   // read by the testbench

    a_tx_stable: assert property (@(posedge clk) disable iff (reset)
        (o_uart_valid && !i_uart_ready) |=> (o_uart_valid && $stable(o_uart_data)))
        else begin
            fail_count++;
            $error("tx valid or data changed while ready was low");
        end

    a_pc_hold: assert property (@(posedge clk) disable iff (reset)
        stall |=> $stable(pc))
        else begin
            fail_count++;
            $error("pc moved during a stall");
        end

    // first edge sees the pc before it is loaded
    a_valid_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !o_uart_valid)
        else begin
            fail_count++;
            $error("tx valid high during reset");
        end

endmodule

bind rv_core rv_core_assert u_assert (
    .clk          (clk),
    .reset        (reset),
    .i_uart_ready (i_uart_ready),
    .o_uart_valid (o_uart_valid),
    .o_uart_data  (o_uart_data),
    .pc           (pc),
    .stall        (stall)
);

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int CYCLES_PER_ROW = 40;
    localparam int TAIL_CYCLES    = 30;   // watch for extra bytes after the table

    logic  clk;
    logic  reset;
    logic  uart_ready;
    logic  uart_valid;
    byte_t uart_data;

    string       row_name [$];
    byte_t       row_byte [$];
    int          errors;
    int          assert_fails;
    int          cycles;
    int          max_cycles;
    int          received;
    logic [31:0] rnd;

    rv_core u_dut (
        .clk          (clk),
        .reset        (reset),
        .i_uart_ready (uart_ready),
        .o_uart_valid (uart_valid),
        .o_uart_data  (uart_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_row(input string name, input byte_t value);
        row_name.push_back(name);
        row_byte.push_back(value);
    endtask

    // transfer happens on the next rising edge if both are high here
    task automatic wait_transfer(output byte_t data, output logic ok);
        ok = 1'b0;
        data = '0;
        while (!ok && cycles < max_cycles) begin
            @(negedge clk);
            cycles++;
            if (uart_valid && uart_ready) begin
                data = uart_data;
                ok = 1'b1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        reset      = 1'b1;
        uart_ready = 1'b0;
        rnd        = 32'h12d9;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            rnd = xorshift(rnd);
            uart_ready = (rnd[1:0] != 2'b00);   // ready about 3 cycles in 4
        end
    end

    initial begin
        byte_t got;
        logic  ok;
        errors       = 0;
        assert_fails = 0;
        cycles       = 0;
        received     = 0;

        add_row("add", 8'h5d);
        add_row("sub", 8'h6b);
        add_row("and", 8'h60);
        add_row("or", 8'hfd);
        add_row("xor", 8'h9d);
        add_row("slt", 8'h01);
        add_row("sltu", 8'h00);
        add_row("sll", 8'h20);
        add_row("srl", 8'h0c);
        add_row("sra", 8'hff);
        add_row("srli", 8'h08);
        add_row("srai", 8'hf8);
        add_row("addi_neg", 8'h9c);
        add_row("lui", 8'hde);
        add_row("auipc", 8'h8c);
        add_row("x0_write", 8'h00);
        add_row("bne_beq", 8'hb1);
        add_row("beq_bne", 8'hb2);
        add_row("blt_bge", 8'hb3);
        add_row("bge_blt", 8'hb4);
        add_row("bltu_bgeu", 8'hb5);
        add_row("bgeu_bltu", 8'hb6);
        add_row("jal_link", 8'h1c);
        add_row("jalr_link", 8'h2c);
        add_row("lw", 8'h64);
        add_row("lb", 8'hff);
        add_row("lbu", 8'h0f);
        add_row("lbu_lane2", 8'h03);
        add_row("lh", 8'hff);
        add_row("lhu", 8'h00);
        add_row("lw_lane0", 8'h64);
        max_cycles = row_name.size() * CYCLES_PER_ROW;

        @(negedge reset);
        for (int i = 0; i < row_name.size(); i++) begin
            wait_transfer(got, ok);
            if (!ok) begin
                $display("timeout: only %0d of %0d bytes were received",
                         received, row_name.size());
                errors++;
                break;
            end
            received++;
            if (got !== row_byte[i]) begin
                $display("mismatch %s: expected %02h, actual %02h",
                         row_name[i], row_byte[i], got);
                errors++;
            end
        end

        for (int i = 0; i < TAIL_CYCLES; i++) begin
            @(negedge clk);
            if (uart_valid && uart_ready) begin
                $display("an extra byte %02h was sent after the last expected one",
                         uart_data);
                errors++;
            end
        end

        assert_fails = u_dut.u_assert.fail_count;
        errors += assert_fails;
        $display("%0d bytes received, %0d assertion failures, %0d errors",
                 received, assert_fails, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== bench/program.hex ====
// one instruction word per line, word address = line order from 0
// x10 holds each result, the sb to x31 sends its low byte
00020FB7  // lui  x31, 0x20
020F8F93  // addi x31, x31, 0x20
06400093  // addi x1, x0, 100
FF900113  // addi x2, x0, -7
00300193  // addi x3, x0, 3
80000237  // lui  x4, 0x80000
00208533  // add
00AF8023  // sb x10, 0(x31)
40208533  // sub
00AF8023
0020F533  // and
00AF8023
0020E533  // or
00AF8023
0020C533  // xor
00AF8023
00112533  // slt x10, x2, x1
00AF8023
00113533  // sltu x10, x2, x1
00AF8023
00309533  // sll x10, x1, x3
00AF8023
0030D533  // srl x10, x1, x3
00AF8023
40315533  // sra x10, x2, x3
00AF8023
01C25513  // srli x10, x4, 28
00AF8023
41C25513  // srai x10, x4, 28
00AF8023
F3808513  // addi x10, x1, -200
00AF8023
ABCDE537  // lui x10, 0xabcde
00C55513  // srli x10, x10, 12
00AF8023
00000517  // auipc x10, 0 at 0x8c
00AF8023
00008013  // addi x0, x1, 0
00000513  // addi x10, x0, 0
00AF8023
00109463  // bne x1, x1, +8
0B100513
00108463  // beq x1, x1, +8
0EE00513  // wrong path marker
00AF8023
00208463  // beq x1, x2, +8
0B200513
00209463  // bne x1, x2, +8
0EE00513
00AF8023
0020C463  // blt x1, x2, +8
0B300513
0020D463  // bge x1, x2, +8
0EE00513
00AF8023
00115463  // bge x2, x1, +8
0B400513
00114463  // blt x2, x1, +8
0EE00513
00AF8023
00116463  // bltu x2, x1, +8
0B500513
00117463  // bgeu x2, x1, +8
0EE00513
00AF8023
0020F463  // bgeu x1, x2, +8
0B600513
0020E463  // bltu x1, x2, +8
0EE00513
00AF8023
0080056F  // jal x10, +8 at 0x118
0EE00513
00AF8023
00000297  // auipc x5, 0 at 0x124
00D28567  // jalr x10, 13(x5)
0EE00513
00AF8023
10000313  // addi x6, x0, 0x100
00232023  // sw x2, 0(x6)
001300A3  // sb x1, 1(x6)
00330123  // sb x3, 2(x6)
002301A3  // sb x2, 3(x6)
00132223  // sw x1, 4(x6)
00331223  // sh x3, 4(x6)
00231323  // sh x2, 6(x6)
00130223  // sb x1, 4(x6)
00032503  // lw x10, 0(x6)
00855513  // srli x10, x10, 8
00AF8023
00330503  // lb x10, 3(x6)
00855513
00AF8023
00334503  // lbu x10, 3(x6)
00455513  // srli x10, x10, 4
00AF8023
00234503  // lbu x10, 2(x6)
00AF8023
00631503  // lh x10, 6(x6)
01055513  // srli x10, x10, 16
00AF8023
00635503  // lhu x10, 6(x6)
01055513
00AF8023
00432503  // lw x10, 4(x6)
00AF8023
0000006F  // jal x0, 0

// ==== rv_core.f ====
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_lsu.sv
hw/rv_core.sv
bench/rv_core_assert.sv
bench/rv_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= rv_core.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# the ROM loads program.hex from the working directory
run: compile
	cd bench && ../$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
